/* bench/icache_mem_model.sv */
`timescale 1ns/1ps

module icache_mem_model
    import icache_pkg::*;
(
    input  logic      Clk,
    input  logic      rst_n,
    input  logic      mem_req_valid,
    output logic      mem_req_ready,
    input  mem_req_t  mem_req,
    output logic      mem_beat_valid,
    output mem_beat_t mem_beat
);

    int          seed = 94;
    logic        took;
    logic [31:0] start;

    // Content of memory at a word-aligned byte address
    function automatic logic [31:0] stored_word(input logic [31:0] byte_addr);
        return {~byte_addr[15:0], byte_addr[15:0]};
    endfunction

    task automatic next_cycle();
        @(posedge Clk);
        #1;
    endtask

    initial begin
        int         gap;
        logic [1:0] off;
        mem_req_ready  = 1'b0;
        mem_beat_valid = 1'b0;
        mem_beat       = '0;
        forever begin
            @(negedge Clk);
            took  = rst_n && mem_req_valid && mem_req_ready;
            start = mem_req.addr;
            next_cycle();
            if (took) begin
                mem_req_ready = 1'b0;
                for (int n = 0; n < BLOCK_WORDS; n++) begin
                    // First beat after 1 to 6 cycles, then gaps of up to 2 cycles
                    if (n == 0) begin
                        gap = $unsigned($random(seed)) % 6;
                    end else begin
                        gap = $unsigned($random(seed)) % 3;
                    end
                    repeat (gap) next_cycle();
                    // Wrap within the block from the requested word
                    off            = start[3:2] + 2'(n);
                    mem_beat_valid = 1'b1;
                    mem_beat.data  = stored_word({start[31:4], off, 2'b00});
                    next_cycle();
                    mem_beat_valid = 1'b0;
                end
            end
            mem_req_ready = ($random(seed) & 3) != 0;
        end
    end

endmodule

/* bench/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    logic       Clk;
    logic       rst_n;
    logic       fetch_req_valid;
    logic       fetch_req_ready;
    fetch_req_t fetch_req;
    logic       fetch_rsp_valid;
    fetch_rsp_t fetch_rsp;
    logic       mem_req_valid;
    logic       mem_req_ready;
    mem_req_t   mem_req;
    logic       mem_beat_valid;
    mem_beat_t  mem_beat;

    int seed       = 94;
    int max_wait   = 2000;
    int cycle      = 0;
    int checks     = 0;
    int mismatches = 0;
    int failures   = 0;

    // Outstanding fetches and memory traffic seen so far
    logic [31:0] pending_addr[$];
    int          pending_cycle[$];
    mem_req_t    mem_log[$];
    int          beat_count   = 0;
    int          last_latency = 0;
    logic        quiet        = 1'b0;

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycle <= cycle + 1;
    end

    icache_top u_dut (
        .Clk             (Clk),
        .rst_n           (rst_n),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .fetch_req       (fetch_req),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req         (mem_req),
        .mem_beat_valid  (mem_beat_valid),
        .mem_beat        (mem_beat)
    );

    icache_mem_model u_mem (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_beat_valid (mem_beat_valid),
        .mem_beat       (mem_beat)
    );

    // Expected instruction word at a byte address
    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        return {~addr[15:0], addr[15:0]};
    endfunction

    task automatic check_rsp(input fetch_rsp_t got, input fetch_rsp_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: fetch_rsp got word %h addr %h, expected word %h addr %h",
                     $time, got.word, got.addr, exp.word, exp.addr);
        end
    endtask

    task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: mem_req got %h expected %h", $time, got.addr, exp.addr);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("error at %0t: %s", $time, what);
    endtask

    // Responses are matched in order against the oldest accepted fetch
    initial begin
        fetch_rsp_t exp;
        forever begin
            @(negedge Clk);
            if (rst_n) begin
                if (fetch_req_valid && fetch_req_ready) begin
                    pending_addr.push_back(fetch_req.addr.raw);
                    pending_cycle.push_back(cycle);
                end
                if (fetch_rsp_valid) begin
                    if (pending_addr.size() == 0) begin
                        report_failure("response arrived with no outstanding fetch");
                    end else begin
                        exp.addr     = pending_addr.pop_front();
                        exp.word     = ref_word(exp.addr);
                        last_latency = cycle - pending_cycle.pop_front();
                        check_rsp(fetch_rsp, exp);
                    end
                end
                if (mem_req_valid && mem_req_ready) begin
                    mem_log.push_back(mem_req);
                end
                if (mem_beat_valid) begin
                    beat_count++;
                end
                quiet = (pending_addr.size() == 0) && fetch_req_ready && !mem_req_valid
                        && (beat_count == BLOCK_WORDS * mem_log.size());
            end
        end
    end

    task automatic step();
        @(posedge Clk);
        #1;
    endtask

    task automatic send_fetch(input logic [31:0] addr);
        int waited;
        waited             = 0;
        fetch_req_valid    = 1'b1;
        fetch_req.addr.raw = addr;
        @(negedge Clk);
        while (!fetch_req_ready && waited < max_wait) begin
            @(negedge Clk);
            waited++;
        end
        if (!fetch_req_ready) begin
            report_failure($sformatf("fetch of %h was never accepted", addr));
        end
        step();
        fetch_req_valid = 1'b0;
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while (pending_addr.size() != 0 && waited < max_wait) begin
            step();
            waited++;
        end
        if (pending_addr.size() != 0) begin
            report_failure("fetch response did not arrive");
        end
    endtask

    // Idle means no fetch open, no request waiting and every burst complete
    task automatic wait_quiet();
        int waited;
        waited = 0;
        step();
        while (!quiet && waited < max_wait) begin
            step();
            waited++;
        end
        if (!quiet) begin
            report_failure("cache and memory never went idle");
        end
    endtask

    task automatic check_logged_req(input int idx, input logic [31:0] addr);
        mem_req_t exp;
        exp.addr = addr;
        if (idx >= mem_log.size()) begin
            report_failure($sformatf("no memory request for %h was seen", addr));
        end else begin
            check_mem_req(mem_log[idx], exp);
        end
    endtask

    task automatic expect_hit(input logic [31:0] addr);
        int reqs_before;
        reqs_before = mem_log.size();
        send_fetch(addr);
        wait_responses();
        if (last_latency != 1) begin
            report_failure($sformatf("hit at %h answered %0d cycles after acceptance",
                                     addr, last_latency));
        end
        if (mem_log.size() != reqs_before) begin
            report_failure($sformatf("hit at %h caused a memory request", addr));
        end
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] rnd;
        int          base;
        rst_n           = 1'b0;
        fetch_req_valid = 1'b0;
        fetch_req       = '0;
        repeat (5) @(posedge Clk);
        #1;
        rst_n = 1'b1;
        wait_quiet();

        // Cold miss at word offset 2, then the prefetch of the next block
        base = mem_log.size();
        send_fetch(32'h0000_1008);
        wait_quiet();
        check_logged_req(base, 32'h0000_1008);
        check_logged_req(base + 1, 32'h0000_1010);

        for (int w = 0; w < BLOCK_WORDS; w++) begin
            expect_hit(32'h0000_1000 + 32'(4 * w));
        end

        // Buffer hit launches the block after it
        base = mem_log.size();
        expect_hit(32'h0000_1014);
        wait_quiet();
        check_logged_req(base, 32'h0000_1020);
        expect_hit(32'h0000_1018);

        // Five blocks of set 5 evict the first one
        for (int k = 0; k < 5; k++) begin
            base = mem_log.size();
            send_fetch(32'h0002_0050 + 32'(k * 128));
            wait_quiet();
            check_logged_req(base, 32'h0002_0050 + 32'(k * 128));
        end
        base = mem_log.size();
        send_fetch(32'h0002_0050);
        wait_quiet();
        check_logged_req(base, 32'h0002_0050);

        // Sequential runs broken by random jumps
        addr = 32'h0000_0400;
        for (int i = 0; i < 400; i++) begin
            rnd = $random(seed);
            if (rnd[2:0] == 3'd0) begin
                addr = {20'h0, rnd[13:4], 2'b00};
            end else begin
                addr = addr + 32'd4;
            end
            send_fetch(addr);
        end
        wait_quiet();

        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0 && checks > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* design/icache_arrays.sv */
`timescale 1ns/1ps

module icache_arrays
    import icache_pkg::*;
(
    input  logic             Clk,
    input  logic             rst_n,
    input  icache_addr_u     lookup_addr,
    input  logic             fill_valid,
    input  fill_t            fill,
    output logic             hit,
    output logic [31:0]      hit_word,
    output logic [WAY_W-1:0] victim_way
);

    logic [TAG_W-1:0]    tag_q   [NUM_SETS][NUM_WAYS];
    block_t              data_q  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [WAY_W-1:0]    rr_q    [NUM_SETS];

    logic [SET_W-1:0] lk_set;
    logic             set_full;

    assign lk_set = lookup_addr.fields.set;

    // Compare the lookup tag against every way of the indexed set
    always_comb begin
        hit      = 1'b0;
        hit_word = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[lk_set][w] && (tag_q[lk_set][w] == lookup_addr.fields.tag)) begin
                hit      = 1'b1;
                hit_word = data_q[lk_set][w][lookup_addr.fields.word_off];
            end
        end
    end

    // Lowest invalid way wins, otherwise the round-robin pointer of the set
    always_comb begin
        victim_way = rr_q[fill.set];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[fill.set][w]) begin
                victim_way = WAY_W'(w);
            end
        end
    end

    assign set_full = &valid_q[fill.set];

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else if (fill_valid) begin
            valid_q[fill.set][victim_way] <= 1'b1;
            // Pointer only moves when it actually picked the victim
            if (set_full) begin
                rr_q[fill.set] <= rr_q[fill.set] + WAY_W'(1);
            end
        end
    end

    // Tag and block storage
    always_ff @(posedge Clk) begin
        if (fill_valid) begin
            tag_q[fill.set][victim_way]  <= fill.tag;
            data_q[fill.set][victim_way] <= fill.data;
        end
    end

endmodule

/* design/icache_mem_port.sv */
`timescale 1ns/1ps

module icache_mem_port
    import icache_pkg::*;
(
    input  logic      Clk,
    input  logic      rst_n,
    input  logic      rf_valid,
    output logic      rf_ready,
    input  mem_req_t  rf_addr,
    input  logic      pf_valid,
    output logic      pf_ready,
    input  mem_req_t  pf_addr,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    output mem_req_t  mem_req,
    input  logic      mem_beat_valid,
    input  mem_beat_t mem_beat,
    output logic      rf_beat_valid,
    output logic      pf_beat_valid,
    output mem_beat_t beat
);

    logic                   open_q;
    logic                   owner_pf_q;
    logic [BLOCK_OFF_W-1:0] cnt_q;

    // Refill wins, and a prefetch sees no ready while refill is asking
    assign rf_ready      = !open_q && mem_req_ready;
    assign pf_ready      = !open_q && !rf_valid && mem_req_ready;
    assign mem_req_valid = !open_q && (rf_valid || pf_valid);
    assign mem_req       = rf_valid ? rf_addr : pf_addr;

    assign rf_beat_valid = mem_beat_valid && open_q && !owner_pf_q;
    assign pf_beat_valid = mem_beat_valid && open_q && owner_pf_q;
    assign beat          = mem_beat;

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            open_q     <= 1'b0;
            owner_pf_q <= 1'b0;
            cnt_q      <= '0;
        end else if (!open_q) begin
            if (mem_req_valid && mem_req_ready) begin
                open_q     <= 1'b1;
                owner_pf_q <= !rf_valid;
                cnt_q      <= '0;
            end
        end else if (mem_beat_valid) begin
            cnt_q <= cnt_q + BLOCK_OFF_W'(1);
            // Burst closes on its last beat
            if (cnt_q == BLOCK_OFF_W'(BLOCK_WORDS - 1)) begin
                open_q <= 1'b0;
            end
        end
    end

endmodule

/* design/icache_pkg.sv */
package icache_pkg;

    // Cache geometry
    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 4;
    localparam int BLOCK_WORDS = 4;

    // Field widths of a byte address
    localparam int WORD_OFF_W  = 2;   // byte within a word
    localparam int BLOCK_OFF_W = 2;   // word within a block
    localparam int SET_W       = 3;
    localparam int WAY_W       = 2;
    localparam int TAG_W       = 25;

    typedef struct packed {
        logic [TAG_W-1:0]       tag;
        logic [SET_W-1:0]       set;
        logic [BLOCK_OFF_W-1:0] word_off;
        logic [WORD_OFF_W-1:0]  byte_off;
    } icache_addr_fields_t;

    // Fetch address seen either as a plain word or split into cache fields
    typedef union packed {
        logic [31:0]         raw;
        icache_addr_fields_t fields;
    } icache_addr_u;

    typedef struct packed {
        icache_addr_u addr;
    } fetch_req_t;

    typedef struct packed {
        logic [31:0] word;
        logic [31:0] addr;
    } fetch_rsp_t;

    typedef struct packed {
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] data;
    } mem_beat_t;

    typedef logic [BLOCK_WORDS-1:0][31:0] block_t;

    typedef struct packed {
        logic [SET_W-1:0] set;
        logic [TAG_W-1:0] tag;
        block_t           data;
    } fill_t;

endpackage

/* design/icache_prefetch.sv */
`timescale 1ns/1ps

module icache_prefetch
    import icache_pkg::*;
(
    input  logic         Clk,
    input  logic         rst_n,
    input  icache_addr_u lookup_addr,
    input  logic         take,
    input  logic         launch,
    input  logic [31:0]  launch_addr,
    output logic         hit,
    output logic [31:0]  hit_word,
    output logic         mem_valid,
    input  logic         mem_ready,
    output mem_req_t     mem_addr,
    input  logic         beat_valid,
    input  mem_beat_t    beat,
    output fill_t        fill
);

    logic                   buf_valid_q;
    logic                   req_q;
    logic                   busy_q;
    logic [BLOCK_OFF_W-1:0] cnt_q;
    icache_addr_u           addr_q;
    block_t                 data_q;
    icache_addr_u           launch_u;
    logic                   accepted;
    logic                   launch_ok;

    // Prefetch always starts at the first word of the block
    always_comb begin
        launch_u.raw             = launch_addr;
        launch_u.fields.word_off = '0;
        launch_u.fields.byte_off = '0;
    end

    assign accepted = req_q && mem_ready;
    // A pending request that lost the port is replaced by the new launch
    assign launch_ok = launch && !busy_q && !accepted;

    assign hit = buf_valid_q && (addr_q.fields.tag == lookup_addr.fields.tag)
                             && (addr_q.fields.set == lookup_addr.fields.set);
    assign hit_word = data_q[lookup_addr.fields.word_off];

    assign mem_valid     = req_q;
    assign mem_addr.addr = addr_q.raw;

    assign fill.set  = addr_q.fields.set;
    assign fill.tag  = addr_q.fields.tag;
    assign fill.data = data_q;

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid_q <= 1'b0;
            req_q       <= 1'b0;
            busy_q      <= 1'b0;
            cnt_q       <= '0;
        end else begin
            if (accepted) begin
                req_q  <= 1'b0;
                busy_q <= 1'b1;
            end else if (launch_ok) begin
                req_q <= 1'b1;
            end
            if (take || launch_ok) begin
                buf_valid_q <= 1'b0;
            end
            if (beat_valid) begin
                cnt_q <= cnt_q + BLOCK_OFF_W'(1);
                if (cnt_q == BLOCK_OFF_W'(BLOCK_WORDS - 1)) begin
                    busy_q      <= 1'b0;
                    buf_valid_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (launch_ok) begin
            addr_q <= launch_u;
        end
        if (beat_valid) begin
            data_q[cnt_q] <= beat.data;
        end
    end

endmodule

/* design/icache_refill.sv */
`timescale 1ns/1ps

module icache_refill
    import icache_pkg::*;
(
    input  logic        Clk,
    input  logic        rst_n,
    input  logic        req_valid,
    output logic        req_ready,
    input  fetch_req_t  req,
    output logic        rsp_valid,
    output fetch_rsp_t  rsp,
    input  logic        array_hit,
    input  logic [31:0] array_word,
    input  logic        pf_hit,
    input  logic [31:0] pf_word,
    input  fill_t       pf_fill,
    output logic        mem_valid,
    input  logic        mem_ready,
    output mem_req_t    mem_addr,
    input  logic        beat_valid,
    input  mem_beat_t   beat,
    output logic        fill_valid,
    output fill_t       fill,
    output logic        pf_take,
    output logic        pf_launch,
    output logic [31:0] pf_launch_addr
);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_BEATS, ST_FILL} state_t;

    state_t                 state_q;
    logic                   take_q;
    logic [BLOCK_OFF_W-1:0] cnt_q;
    icache_addr_u           addr_q;
    block_t                 block_q;
    logic                   accept;
    logic [BLOCK_OFF_W-1:0] beat_idx;

    // No new request while the buffer block is being moved
    assign req_ready = (state_q == ST_IDLE) && !take_q;
    assign accept    = req_valid && req_ready;

    assign mem_valid     = (state_q == ST_REQ);
    assign mem_addr.addr = addr_q.raw;

    // Beats wrap around the block starting at the critical word
    assign beat_idx = addr_q.fields.word_off + cnt_q;

    assign pf_take        = take_q;
    assign pf_launch      = (state_q == ST_FILL) || take_q;
    assign pf_launch_addr = {addr_q.fields.tag, addr_q.fields.set,
                             {(BLOCK_OFF_W + WORD_OFF_W){1'b0}}} + 32'(BLOCK_WORDS * 4);

    assign fill_valid = (state_q == ST_FILL) || take_q;

    always_comb begin
        if (take_q) begin
            fill = pf_fill;
        end else begin
            fill.set  = addr_q.fields.set;
            fill.tag  = addr_q.fields.tag;
            fill.data = block_q;
        end
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            take_q    <= 1'b0;
            rsp_valid <= 1'b0;
            cnt_q     <= '0;
        end else begin
            rsp_valid <= 1'b0;
            take_q    <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        if (array_hit || pf_hit) begin
                            rsp_valid <= 1'b1;
                            take_q    <= !array_hit;
                        end else begin
                            state_q <= ST_REQ;
                        end
                    end
                end
                ST_REQ: begin
                    cnt_q <= '0;
                    if (mem_ready) begin
                        state_q <= ST_BEATS;
                    end
                end
                ST_BEATS: begin
                    if (beat_valid) begin
                        cnt_q <= cnt_q + BLOCK_OFF_W'(1);
                        // Critical word goes straight back to the core
                        if (cnt_q == '0) begin
                            rsp_valid <= 1'b1;
                        end
                        if (cnt_q == BLOCK_OFF_W'(BLOCK_WORDS - 1)) begin
                            state_q <= ST_FILL;
                        end
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            addr_q   <= req.addr;
            rsp.addr <= req.addr.raw;
            rsp.word <= array_hit ? array_word : pf_word;
        end
        if ((state_q == ST_BEATS) && beat_valid) begin
            block_q[beat_idx] <= beat.data;
            if (cnt_q == '0) begin
                rsp.word <= beat.data;
            end
        end
    end

endmodule

/* design/icache_top.sv */
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    input  logic       Clk,
    input  logic       rst_n,
    input  logic       fetch_req_valid,
    output logic       fetch_req_ready,
    input  fetch_req_t fetch_req,
    output logic       fetch_rsp_valid,
    output fetch_rsp_t fetch_rsp,
    output logic       mem_req_valid,
    input  logic       mem_req_ready,
    output mem_req_t   mem_req,
    input  logic       mem_beat_valid,
    input  mem_beat_t  mem_beat
);

    logic        arr_hit;
    logic [31:0] arr_word;
    logic        pf_hit;
    logic [31:0] pf_word;
    fill_t       pf_fill;
    logic        fill_valid;
    fill_t       fill;
    logic        pf_take;
    logic        pf_launch;
    logic [31:0] pf_launch_addr;
    logic        rf_mem_valid;
    logic        rf_mem_ready;
    mem_req_t    rf_mem_addr;
    logic        pf_mem_valid;
    logic        pf_mem_ready;
    mem_req_t    pf_mem_addr;
    logic        rf_beat_valid;
    logic        pf_beat_valid;
    mem_beat_t   port_beat;

    // Victim way is only needed inside the arrays
    icache_arrays u_arrays (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .lookup_addr (fetch_req.addr),
        .fill_valid  (fill_valid),
        .fill        (fill),
        .hit         (arr_hit),
        .hit_word    (arr_word),
        .victim_way  ()
    );

    icache_refill u_refill (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .req_valid      (fetch_req_valid),
        .req_ready      (fetch_req_ready),
        .req            (fetch_req),
        .rsp_valid      (fetch_rsp_valid),
        .rsp            (fetch_rsp),
        .array_hit      (arr_hit),
        .array_word     (arr_word),
        .pf_hit         (pf_hit),
        .pf_word        (pf_word),
        .pf_fill        (pf_fill),
        .mem_valid      (rf_mem_valid),
        .mem_ready      (rf_mem_ready),
        .mem_addr       (rf_mem_addr),
        .beat_valid     (rf_beat_valid),
        .beat           (port_beat),
        .fill_valid     (fill_valid),
        .fill           (fill),
        .pf_take        (pf_take),
        .pf_launch      (pf_launch),
        .pf_launch_addr (pf_launch_addr)
    );

    icache_prefetch u_prefetch (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .lookup_addr (fetch_req.addr),
        .take        (pf_take),
        .launch      (pf_launch),
        .launch_addr (pf_launch_addr),
        .hit         (pf_hit),
        .hit_word    (pf_word),
        .mem_valid   (pf_mem_valid),
        .mem_ready   (pf_mem_ready),
        .mem_addr    (pf_mem_addr),
        .beat_valid  (pf_beat_valid),
        .beat        (port_beat),
        .fill        (pf_fill)
    );

    icache_mem_port u_mem_port (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .rf_valid       (rf_mem_valid),
        .rf_ready       (rf_mem_ready),
        .rf_addr        (rf_mem_addr),
        .pf_valid       (pf_mem_valid),
        .pf_ready       (pf_mem_ready),
        .pf_addr        (pf_mem_addr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_beat_valid (mem_beat_valid),
        .mem_beat       (mem_beat),
        .rf_beat_valid  (rf_beat_valid),
        .pf_beat_valid  (pf_beat_valid),
        .beat           (port_beat)
    );

endmodule

/* icache_sub.f */
design/icache_pkg.sv
design/icache_arrays.sv
design/icache_refill.sv
design/icache_prefetch.sv
design/icache_mem_port.sv
design/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module icache_tb -Mdir obj_dir -f icache_sub.f

output=$(./obj_dir/Vicache_tb)
echo "$output"

if echo "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
